// File: Makefile
SRCS := $(filter-out +incdir%,$(shell cat all.f)) design/tetris_config.svh

.PHONY: run clean

run: obj_dir/Vtb_tetris_move
	@out=$$(./obj_dir/Vtb_tetris_move); echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

obj_dir/Vtb_tetris_move: all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_tetris_move -o Vtb_tetris_move

clean:
	rm -rf obj_dir

// File: all.f
+incdir+design
design/tetris_pkg.sv
design/tetromino_render.sv
design/wall_kick_table.sv
design/playfield_store.sv
design/move_validity.sv
design/tetris_move_top.sv
tb/tb_tetris_move.sv

// File: design/move_validity.sv
// one request per five cycle sweep; the field must stay stable while req_ready is low.
`timescale 1ns/1ps
`include "tetris_config.svh"

module move_validity (
    input  logic                     clk,
    input  logic                     rst_l,
    input  logic                     req_valid,
    input  tetris_pkg::piece_t       req_piece,
    output logic                     req_ready,
    input  tetris_pkg::field_t       field,
    output logic                     rsp_valid,
    output tetris_pkg::move_result_t rsp_result
);
    tetris_pkg::sweep_state_t  state;
    tetris_pkg::piece_t        piece;
    logic [2:0]                k;            // sweep step, also the kick index.
    logic                      accept;
    logic                      last;

    logic [4:0]                cand_row;
    logic [4:0]                cand_col;
    logic [3:0][4:0]           cand_rows;
    logic [3:0][4:0]           cand_cols;
    logic                      cand_fit;
    logic [2:0]                shift_ok;     // right, left, drop.

    tetris_pkg::orient_t       rot_orient [2];   // entry 0 turns right.
    logic [1:0][4:0]           kick_d_row;
    logic [1:0][4:0]           kick_d_col;
    logic [1:0][4:0]           kick_row;
    logic [1:0][4:0]           kick_col;
    logic [1:0][3:0][4:0]      rot_rows;
    logic [1:0][3:0][4:0]      rot_cols;
    logic [1:0]                rot_fit;
    logic [1:0]                rot_found;
    logic [1:0][9:0]           rot_org;
    tetris_pkg::rot_result_t [1:0] rot_res;

    // a tile fails off the sides, below the floor or on a locked cell.
    function automatic logic fits(input logic [3:0][4:0] rows, input logic [3:0][4:0] cols,
                                  input tetris_pkg::field_t fld);
        logic ok;
        ok = 1'b1;
        for (int n = 0; n < 4; n++) begin
            if (cols[n] >= `TETRIS_COLS) begin
                ok = 1'b0;
            end else if (rows[n] < `TETRIS_ROWS) begin
                if (fld[rows[n]][cols[n]] != tetris_pkg::blank) begin
                    ok = 1'b0;
                end
            end else if (rows[n] < `TETRIS_ABOVE) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    assign accept    = req_valid && req_ready;
    assign last      = (state == tetris_pkg::sweep_run) && (k == 3'(`TETRIS_KICKS - 1));
    assign req_ready = (state == tetris_pkg::sweep_idle);
    assign rsp_valid = (state == tetris_pkg::sweep_done);

    // **************************************************
    // shift and drop candidates, one per step
    // **************************************************
    always_comb begin
        cand_row = piece.row;
        cand_col = piece.col;
        case (k)
            3'd0:    cand_col = piece.col + 5'd1;
            3'd1:    cand_col = piece.col - 5'd1;
            default: cand_row = piece.row + 5'd1;
        endcase
    end

    tetromino_render i_cand_render (
        .kind     (piece.kind),
        .orient   (piece.orient),
        .row      (cand_row),
        .col      (cand_col),
        .tile_row (cand_rows),
        .tile_col (cand_cols)
    );

    assign cand_fit = fits(cand_rows, cand_cols, field);

    // **************************************************
    // rotations, kick k tested at step k
    // **************************************************
    assign rot_orient[0] = tetris_pkg::orient_t'(piece.orient + 2'd1);
    assign rot_orient[1] = tetris_pkg::orient_t'(piece.orient - 2'd1);

    for (genvar d = 0; d < 2; d++) begin : g_rot
        wall_kick_table i_kick (
            .is_i       (piece.kind == tetris_pkg::i),
            .to_orient  (rot_orient[d]),
            .turn_right (d == 0),
            .index      (k),
            .d_row      (kick_d_row[d]),
            .d_col      (kick_d_col[d])
        );

        assign kick_row[d] = piece.row + kick_d_row[d];
        assign kick_col[d] = piece.col + kick_d_col[d];

        tetromino_render i_render (
            .kind     (piece.kind),
            .orient   (rot_orient[d]),
            .row      (kick_row[d]),
            .col      (kick_col[d]),
            .tile_row (rot_rows[d]),
            .tile_col (rot_cols[d])
        );

        assign rot_fit[d] = fits(rot_rows[d], rot_cols[d], field);
    end

    // first fit wins, the current step still counts when nothing fit before.
    always_comb begin
        for (int d = 0; d < 2; d++) begin
            rot_res[d].valid = rot_found[d] | rot_fit[d];
            if (!rot_found[d] && rot_fit[d]) begin
                rot_res[d].row = kick_row[d];
                rot_res[d].col = kick_col[d];
            end else begin
                {rot_res[d].row, rot_res[d].col} = rot_org[d];
            end
        end
    end

    // **************************************************
    // sweep control and result
    // **************************************************
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state      <= tetris_pkg::sweep_idle;
            k          <= 3'd0;
            rsp_result <= '0;
        end else begin
            case (state)
                tetris_pkg::sweep_idle: begin
                    k <= 3'd0;
                    if (accept) begin
                        state <= tetris_pkg::sweep_run;
                    end
                end
                tetris_pkg::sweep_run: begin
                    k <= k + 3'd1;
                    if (last) begin
                        state      <= tetris_pkg::sweep_done;
                        rsp_result <= {shift_ok[0], shift_ok[1], shift_ok[2],
                                       rot_res[0], rot_res[1]};
                    end
                end
                default: state <= tetris_pkg::sweep_idle;   // one cycle pulse.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            piece <= req_piece;
        end
        if (state == tetris_pkg::sweep_run) begin
            if (k < 3'd3) begin
                shift_ok[k[1:0]] <= cand_fit;
            end
            for (int d = 0; d < 2; d++) begin
                if (k == 3'd0) begin
                    rot_found[d] <= rot_fit[d];
                    rot_org[d]   <= {piece.row, piece.col};   // kick 0 is the origin.
                end else if (!rot_found[d] && rot_fit[d]) begin
                    rot_found[d] <= 1'b1;
                    rot_org[d]   <= {kick_row[d], kick_col[d]};
                end
            end
        end
    end

endmodule

// File: design/playfield_store.sv
// zero wait state APB slave; out of range accesses error, writes are dropped and reads give blank.
`timescale 1ns/1ps
`include "tetris_config.svh"

module playfield_store (
    input  logic               clk,
    input  logic               rst_l,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [8:0]         paddr,
    input  logic [3:0]         pwdata,
    output logic [3:0]         prdata,
    output logic               pready,
    output logic               pslverr,
    output tetris_pkg::field_t field
);
    logic [4:0] row;
    logic [3:0] col;
    logic       in_range;
    logic       access;

    assign row      = paddr[8:4];
    assign col      = paddr[3:0];
    assign in_range = (row < `TETRIS_ROWS) && (col < `TETRIS_COLS);
    assign access   = psel && penable;   // access phase.

    assign pready   = 1'b1;
    assign pslverr  = access && !in_range;
    assign prdata   = in_range ? field[row][col] : tetris_pkg::blank;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            field <= tetris_pkg::field_t'('0);   // all blank.
        end else if (access && pwrite && in_range) begin
            field[row][col] <= tetris_pkg::tile_t'(pwdata);
        end
    end

endmodule

// File: design/tetris_config.svh
// field size and kick count are fixed here; rows 30 and 31 stand for cells above the field.
`ifndef TETRIS_CONFIG_SVH
`define TETRIS_CONFIG_SVH

// **************************************************
// playfield geometry
// **************************************************
`define TETRIS_ROWS  20   // row 0 is the top row.
`define TETRIS_COLS  10

// **************************************************
// move checking
// **************************************************
`define TETRIS_KICKS 5    // kick tests per rotation, test 0 is no kick.
`define TETRIS_ABOVE 30   // first wrapped row value that lies above the field.

`endif

// File: design/tetris_move_top.sv
// response comes six clock edges after acceptance; APB writes must not overlap a sweep.
`timescale 1ns/1ps

module tetris_move_top (
    input  logic                     clk,
    input  logic                     rst_l,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [8:0]               paddr,
    input  logic [3:0]               pwdata,
    output logic [3:0]               prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     req_valid,
    input  tetris_pkg::piece_t       req_piece,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output tetris_pkg::move_result_t rsp_result
);
    tetris_pkg::field_t field;   // locked cells.

    playfield_store i_playfield_store (
        .clk     (clk),
        .rst_l   (rst_l),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .field   (field)
    );

    move_validity i_move_validity (
        .clk        (clk),
        .rst_l      (rst_l),
        .req_valid  (req_valid),
        .req_piece  (req_piece),
        .req_ready  (req_ready),
        .field      (field),
        .rsp_valid  (rsp_valid),
        .rsp_result (rsp_result)
    );

endmodule

// File: design/tetris_pkg.sv
// blank must stay encoded as zero, the store relies on it to clear the field at reset.
`include "tetris_config.svh"

package tetris_pkg;

    typedef enum logic [3:0] {
        blank,
        i,
        o,
        t,
        s,
        z,
        j,
        l
    } tile_t;

    typedef enum logic [1:0] {
        or_0,
        or_r,
        or_2,
        or_l
    } orient_t;   // clockwise order.

    typedef struct packed {
        tile_t      kind;
        orient_t    orient;
        logic [4:0] row;
        logic [4:0] col;
    } piece_t;

    typedef tile_t [`TETRIS_ROWS-1:0][`TETRIS_COLS-1:0] field_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] row;   // kicked origin.
        logic [4:0] col;
    } rot_result_t;

    typedef struct packed {
        logic        move_r;
        logic        move_l;
        logic        soft_drop;
        rot_result_t rot_r;
        rot_result_t rot_l;
    } move_result_t;

    typedef enum logic [1:0] {
        sweep_idle,
        sweep_run,
        sweep_done
    } sweep_state_t;

endpackage

// File: design/tetromino_render.sv
// origin is cell (1,1) of the 4x4 shape box; coordinates wrap in five bits, no range check.
`timescale 1ns/1ps

module tetromino_render (
    input  tetris_pkg::tile_t   kind,
    input  tetris_pkg::orient_t orient,
    input  logic [4:0]          row,
    input  logic [4:0]          col,
    output logic [3:0][4:0]     tile_row,
    output logic [3:0][4:0]     tile_col
);
    // one 16 bit box per orientation, bit 4*r+c, entry 0 is or_0.
    localparam logic [3:0][15:0] I_SHAPE = {16'h2222, 16'h0F00, 16'h4444, 16'h00F0};
    localparam logic [3:0][15:0] O_SHAPE = {16'h0066, 16'h0066, 16'h0066, 16'h0066};
    localparam logic [3:0][15:0] T_SHAPE = {16'h0232, 16'h0270, 16'h0262, 16'h0072};
    localparam logic [3:0][15:0] S_SHAPE = {16'h0231, 16'h0360, 16'h0462, 16'h0036};
    localparam logic [3:0][15:0] Z_SHAPE = {16'h0132, 16'h0630, 16'h0264, 16'h0063};
    localparam logic [3:0][15:0] J_SHAPE = {16'h0322, 16'h0470, 16'h0226, 16'h0071};
    localparam logic [3:0][15:0] L_SHAPE = {16'h0223, 16'h0170, 16'h0622, 16'h0074};

    logic [15:0] mask;
    logic [2:0]  n;   // tiles placed so far.

    always_comb begin
        case (kind)
            tetris_pkg::i: mask = I_SHAPE[orient];
            tetris_pkg::o: mask = O_SHAPE[orient];
            tetris_pkg::t: mask = T_SHAPE[orient];
            tetris_pkg::s: mask = S_SHAPE[orient];
            tetris_pkg::z: mask = Z_SHAPE[orient];
            tetris_pkg::j: mask = J_SHAPE[orient];
            tetris_pkg::l: mask = L_SHAPE[orient];
            default:       mask = 16'h0000;
        endcase
    end

    // walk the box in row order and hand out the four occupied cells.
    always_comb begin
        n        = 3'd0;
        tile_row = {4{row}};   // a blank piece collapses onto its origin.
        tile_col = {4{col}};
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (mask[4*r+c] && n < 3'd4) begin
                    tile_row[n[1:0]] = row + 5'(r) - 5'd1;
                    tile_col[n[1:0]] = col + 5'(c) - 5'd1;
                    n                = n + 3'd1;
                end
            end
        end
    end

endmodule

// File: design/wall_kick_table.sv
// offsets are five bit two's complement in field rows and columns; index 0 and 5 to 7 give zero.
`timescale 1ns/1ps

module wall_kick_table (
    input  logic                is_i,
    input  tetris_pkg::orient_t to_orient,
    input  logic                turn_right,
    input  logic [2:0]          index,
    output logic [4:0]          d_row,
    output logic [4:0]          d_col
);
    logic [1:0] key;     // clockwise-equivalent target for the I table.
    logic [4:0] bx;      // base offset, x to the right.
    logic [4:0] by;      // base offset, y upward.
    logic       neg_x;
    logic       neg_y;

    always_comb begin
        key   = turn_right ? to_orient : to_orient - 2'd1;
        bx    = 5'd0;
        by    = 5'd0;
        neg_x = 1'b0;
        neg_y = 1'b0;
        if (is_i) begin
            // odd key uses the 0->R set, even key the R->2 set; keys 0 and L mirror them.
            case (index)
                3'd1:    {bx, by} = key[0] ? {-5'sd2, 5'sd0}  : {-5'sd1, 5'sd0};
                3'd2:    {bx, by} = key[0] ? {5'sd1, 5'sd0}   : {5'sd2, 5'sd0};
                3'd3:    {bx, by} = key[0] ? {-5'sd2, -5'sd1} : {-5'sd1, 5'sd2};
                3'd4:    {bx, by} = key[0] ? {5'sd1, 5'sd2}   : {5'sd2, -5'sd1};
                default: {bx, by} = 10'd0;
            endcase
            neg_x = ~^key;
            neg_y = ~^key;
        end else begin
            // one pattern, mirrored in x by the side turned from and in y by the target.
            case (index)
                3'd1:    {bx, by} = {5'sd1, 5'sd0};
                3'd2:    {bx, by} = {5'sd1, 5'sd1};
                3'd3:    {bx, by} = {5'sd0, -5'sd2};
                3'd4:    {bx, by} = {5'sd1, -5'sd2};
                default: {bx, by} = 10'd0;
            endcase
            neg_x = (to_orient == tetris_pkg::or_r) ||
                    (to_orient == tetris_pkg::or_0 && turn_right) ||
                    (to_orient == tetris_pkg::or_2 && !turn_right);
            neg_y = !to_orient[0];
        end
        d_col = neg_x ? -bx : bx;
        d_row = neg_y ? by : -by;   // rows grow downward.
    end

endmodule

// File: tb/tb_tetris_move.sv
// expects an empty field between tests; APB traffic never overlaps a sweep, which the DUT requires.
`timescale 1ns/1ps
`include "tetris_config.svh"

module tb_tetris_move;
    localparam int    NUM_REQ    = 40;     // planned requests, with margin.
    localparam int    APB_OPS    = 300;    // three cycles each.
    localparam longint TIMEOUT_NS = (NUM_REQ * 20 + APB_OPS * 3 + 100) * 10;

    logic                     clk = 1'b0;
    logic                     rst_l;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [8:0]               paddr;
    logic [3:0]               pwdata;
    logic [3:0]               prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     req_valid;
    tetris_pkg::piece_t       req_piece;
    logic                     req_ready;
    logic                     rsp_valid;
    tetris_pkg::move_result_t rsp_result;

    logic [3:0]               mirror [`TETRIS_ROWS][`TETRIS_COLS];   // locked cells as written.
    int                       errors = 0;
    int                       responses = 0;
    int unsigned              rng = 83;
    logic                     busy = 1'b0;
    int                       age;
    tetris_pkg::move_result_t expect_rsp;
    tetris_pkg::move_result_t last_rsp = '0;

    tetris_move_top i_tetris_move_top (.*);

    always #5 clk = ~clk;

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    function automatic int unsigned next_random();
        rng = rng * 32'd1103515245 + 32'd12345;
        return (rng >> 16) & 32'h7fff;
    endfunction

    // **************************************************
    // reference model of shapes and kicks
    // **************************************************
    // cell n of the piece as {row, col} in its box; rotation turns the box clockwise.
    function automatic logic [3:0] shape_cell(input logic [3:0] kind, input logic [1:0] orient,
                                              input int n);
        logic [15:0] base;
        logic [1:0]  r;
        logic [1:0]  c;
        logic [1:0]  t;
        case (kind)
            4'd1:    base = 16'h4567;
            4'd2:    base = 16'h1256;
            4'd3:    base = 16'h1456;
            4'd4:    base = 16'h1245;
            4'd5:    base = 16'h0156;
            4'd6:    base = 16'h0456;
            default: base = 16'h2456;
        endcase
        {r, c} = base[15-4*n -: 4];
        for (int q = 0; q < int'(orient); q++) begin
            if (kind != 4'd2) begin   // o never moves.
                t = r;
                r = c;
                c = ((kind == 4'd1) ? 2'd3 : 2'd2) - t;
            end
        end
        return {r, c};
    endfunction

    function automatic logic cell_free(input logic [4:0] row, input logic [4:0] col);
        if (col >= `TETRIS_COLS) return 1'b0;
        if (row >= `TETRIS_ABOVE) return 1'b1;
        if (row >= `TETRIS_ROWS) return 1'b0;
        return mirror[row][col] == 4'd0;
    endfunction

    function automatic logic piece_fits(input logic [3:0] kind, input logic [1:0] orient,
                                        input logic [4:0] row, input logic [4:0] col);
        logic [3:0] rc;
        logic       ok;
        ok = 1'b1;
        for (int n = 0; n < 4; n++) begin
            rc = shape_cell(kind, orient, n);
            ok &= cell_free(row + {3'b0, rc[3:2]} - 5'd1, col + {3'b0, rc[1:0]} - 5'd1);
        end
        return ok;
    endfunction

    // {d_row, d_col}; table x is to the right and y upward.
    function automatic logic [9:0] kick_offset(input logic [3:0] kind, input logic [1:0] from,
                                               input logic [1:0] to, input int idx);
        int ax [4] = '{-2, 1, -2, 1};
        int ay [4] = '{0, 0, -1, 2};
        int bx [4] = '{-1, 2, -1, 2};
        int by [4] = '{0, 0, 2, -1};
        int x;
        int y;
        int s;
        if (idx == 0) return 10'd0;
        if (kind == 4'd1) begin
            case ({from, to})
                4'b0001, 4'b1110: begin
                    x = ax[idx-1];
                    y = ay[idx-1];
                end
                4'b0100, 4'b1011: begin
                    x = -ax[idx-1];
                    y = -ay[idx-1];
                end
                4'b0110, 4'b0011: begin
                    x = bx[idx-1];
                    y = by[idx-1];
                end
                default: begin
                    x = -bx[idx-1];
                    y = -by[idx-1];
                end
            endcase
        end else begin
            s = (to == 2'd1 || from == 2'd3) ? -1 : 1;
            x = (idx == 3) ? 0 : s;
            y = (idx == 1) ? 0 : (idx == 2) ? 1 : -2;
            if (!to[0]) y = -y;
        end
        return {5'(-y), 5'(x)};
    endfunction

    function automatic tetris_pkg::move_result_t expected_moves(input tetris_pkg::piece_t p);
        tetris_pkg::move_result_t m;
        tetris_pkg::rot_result_t  rr [2];
        logic [9:0]               off;
        logic [1:0]               to;
        m = '0;
        m.move_r    = piece_fits(p.kind, p.orient, p.row, p.col + 5'd1);
        m.move_l    = piece_fits(p.kind, p.orient, p.row, p.col - 5'd1);
        m.soft_drop = piece_fits(p.kind, p.orient, p.row + 5'd1, p.col);
        for (int d = 0; d < 2; d++) begin
            to = (d == 0) ? p.orient + 2'd1 : p.orient - 2'd1;
            rr[d] = '{1'b0, p.row, p.col};
            for (int idx = 0; idx < `TETRIS_KICKS; idx++) begin
                off = kick_offset(p.kind, p.orient, to, idx);
                if (!rr[d].valid && piece_fits(p.kind, to, p.row + off[9:5], p.col + off[4:0]))
                    rr[d] = '{1'b1, p.row + off[9:5], p.col + off[4:0]};
            end
        end
        m.rot_r = rr[0];
        m.rot_l = rr[1];
        return m;
    endfunction

    // extent of the tiles relative to the origin, for placing pieces at walls.
    function automatic int extent(input logic [3:0] kind, input logic [1:0] orient,
                                  input bit of_col, input bit want_max);
        int v;
        int e;
        e = want_max ? -9 : 9;
        for (int n = 0; n < 4; n++) begin
            v = of_col ? int'(shape_cell(kind, orient, n) & 4'h3) - 1
                       : int'(shape_cell(kind, orient, n) >> 2) - 1;
            if (want_max ? v > e : v < e) e = v;
        end
        return e;
    endfunction

    // **************************************************
    // response monitor, sampled before the edge updates
    // **************************************************
    always @(posedge clk) begin
        if (rst_l) begin
            if (busy) begin
                age = age + 1;
                assert (req_ready === 1'b0) else report_value("req_ready", req_ready, 0);
                if (age < 6) begin
                    assert (rsp_valid === 1'b0) else report_value("rsp_valid", rsp_valid, 0);
                    assert (rsp_result === last_rsp) else
                        report_value("rsp_result", rsp_result, last_rsp);
                end else begin
                    assert (rsp_valid === 1'b1) else report_value("rsp_valid", rsp_valid, 1);
                    assert (rsp_result === expect_rsp) else
                        report_value("rsp_result", rsp_result, expect_rsp);
                    last_rsp = rsp_result;
                    busy = 1'b0;
                    responses++;
                end
            end else begin
                assert (rsp_valid === 1'b0) else report_value("rsp_valid", rsp_valid, 0);
                assert (rsp_result === last_rsp) else
                    report_value("rsp_result", rsp_result, last_rsp);
            end
            if (req_valid && req_ready) begin
                busy       = 1'b1;
                age        = 0;
                expect_rsp = expected_moves(req_piece);
            end
        end
    end

    // **************************************************
    // stimulus tasks
    // **************************************************
    task automatic apb_access(input int row, input int col, input bit wr, input logic [3:0] val);
        logic err;
        logic [3:0] exp;
        err = (row >= `TETRIS_ROWS) || (col >= `TETRIS_COLS);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = {5'(row), 4'(col)};
        pwdata  = val;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        exp = err ? 4'd0 : mirror[row][col];
        assert (pslverr === err) else report_value("pslverr", pslverr, err);
        assert (pready === 1'b1) else report_value("pready", pready, 1);
        if (!wr) begin
            assert (prdata === exp) else report_value("prdata", prdata, exp);
        end else if (!err) begin
            mirror[row][col] = val;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic clear_field();
        for (int r = 0; r < `TETRIS_ROWS; r++)
            for (int c = 0; c < `TETRIS_COLS; c++)
                if (mirror[r][c] != 4'd0) apb_access(r, c, 1'b1, 4'd0);
    endtask

    task automatic send_request(input tetris_pkg::piece_t p);
        @(negedge clk);
        req_valid = 1'b1;
        req_piece = p;
        while (!req_ready) @(negedge clk);   // held until the checker is free.
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic check_piece(input tetris_pkg::piece_t p);
        send_request(p);
        while (busy) @(negedge clk);
    endtask

    function automatic tetris_pkg::piece_t centre_piece();
        tetris_pkg::piece_t p;
        p.kind   = tetris_pkg::tile_t'(4'(1 + next_random() % 7));
        p.orient = tetris_pkg::orient_t'(2'(next_random() % 4));
        p.row    = 5'(8 + next_random() % 4);
        p.col    = 5'(4 + next_random() % 2);
        return p;
    endfunction

    // **************************************************
    // test sequence
    // **************************************************
    initial begin
        tetris_pkg::piece_t p;
        tetris_pkg::piece_t q;
        rst_l = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        req_valid = 1'b0;
        req_piece = '0;
        for (int r = 0; r < `TETRIS_ROWS; r++)
            for (int c = 0; c < `TETRIS_COLS; c++)
                mirror[r][c] = 4'd0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_l = 1'b1;
        assert (req_ready === 1'b1) else report_value("req_ready", req_ready, 1);
        assert (pslverr === 1'b0) else report_value("pslverr", pslverr, 0);
        assert (rsp_result === '0) else report_value("rsp_result", rsp_result, 0);

        // playfield access, including out of range writes and reads.
        apb_access(3, 4, 1'b1, 4'd3);
        apb_access(19, 9, 1'b1, 4'd7);
        apb_access(0, 0, 1'b1, 4'd1);
        apb_access(20, 3, 1'b1, 4'd5);
        apb_access(2, 10, 1'b1, 4'd5);
        apb_access(3, 4, 1'b0, 4'd0);
        apb_access(19, 9, 1'b0, 4'd0);
        apb_access(0, 0, 1'b0, 4'd0);
        apb_access(20, 3, 1'b0, 4'd0);
        apb_access(2, 9, 1'b0, 4'd0);
        clear_field();

        // open field, then a request held while the checker is busy.
        for (int n = 0; n < 14; n++) begin
            p = centre_piece();
            check_piece(p);
            assert (last_rsp.move_r && last_rsp.move_l && last_rsp.soft_drop &&
                    last_rsp.rot_r.valid && last_rsp.rot_l.valid) else
                report_problem("open field move was reported invalid");
            assert (last_rsp.rot_r.row == p.row && last_rsp.rot_r.col == p.col &&
                    last_rsp.rot_l.row == p.row && last_rsp.rot_l.col == p.col) else
                report_problem("open field rotation used a kick");
        end
        p = centre_piece();
        q = centre_piece();
        send_request(p);
        send_request(q);
        while (busy) @(negedge clk);

        // walls, floor and rows above the field.
        for (int n = 0; n < 3; n++) begin
            p = centre_piece();
            p.col = 5'(-extent(p.kind, p.orient, 1, 0));
            check_piece(p);
            assert (!last_rsp.move_l) else report_problem("left shift allowed at column 0");
            p.col = 5'(9 - extent(p.kind, p.orient, 1, 1));
            check_piece(p);
            assert (!last_rsp.move_r) else report_problem("right shift allowed at column 9");
            p.row = 5'(19 - extent(p.kind, p.orient, 0, 1));
            check_piece(p);
            assert (!last_rsp.soft_drop) else report_problem("soft drop allowed on the floor");
        end
        check_piece('{tetris_pkg::t, tetris_pkg::or_0, 5'd0, 5'd4});
        assert (last_rsp.move_r && last_rsp.move_l) else
            report_problem("piece above the field was rejected");
        check_piece('{tetris_pkg::i, tetris_pkg::or_r, 5'd31, 5'd4});

        // one locked cell beside a T.
        apb_access(10, 6, 1'b1, 4'd2);
        check_piece('{tetris_pkg::t, tetris_pkg::or_0, 5'd10, 5'd4});
        assert (!last_rsp.move_r && last_rsp.move_l) else
            report_problem("locked cell did not block only the right shift");
        clear_field();

        // wall kicks against walls and locked cells.
        check_piece('{tetris_pkg::t, tetris_pkg::or_r, 5'd10, 5'd0});
        assert (last_rsp.rot_r.valid && last_rsp.rot_r.col != 5'd0) else
            report_problem("T at the left wall did not kick");
        check_piece('{tetris_pkg::i, tetris_pkg::or_r, 5'd10, 5'd31});
        check_piece('{tetris_pkg::i, tetris_pkg::or_l, 5'd10, 5'd9});
        apb_access(11, 4, 1'b1, 4'd6);
        check_piece('{tetris_pkg::t, tetris_pkg::or_0, 5'd10, 5'd4});
        clear_field();

        // T fully enclosed by locked cells.
        for (int r = 6; r < 15; r++)
            for (int c = 0; c < `TETRIS_COLS; c++)
                if (!(r == 10 && c >= 3 && c <= 5) && !(r == 9 && c == 4))
                    apb_access(r, c, 1'b1, 4'd4);
        check_piece('{tetris_pkg::t, tetris_pkg::or_0, 5'd10, 5'd4});
        assert (!last_rsp.rot_r.valid && !last_rsp.rot_l.valid) else
            report_problem("enclosed piece could rotate");
        assert (last_rsp.rot_r.row == 5'd10 && last_rsp.rot_r.col == 5'd4 &&
                last_rsp.rot_l.row == 5'd10 && last_rsp.rot_l.col == 5'd4) else
            report_problem("enclosed piece moved its origin");
        clear_field();

        repeat (4) @(negedge clk);
        $display("errors: %0d, responses checked: %0d", errors, responses);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
